/* hw/i2c_bus_sampler.sv */
// SCL and SDA are asynchronous to SYSCLK; each SCL phase must last 8 SYSCLK cycles or more
module i2c_bus_sampler
(
	input  logic                      SYSCLK,
	input  logic                      RESET_N,
	input  logic                      scl,
	input  logic                      sda_in,
	output i2c_slave_pkg::bus_event_t events
);
	import i2c_slave_pkg::*;

	logic [2:0] scl_sync;   // Two sync stages then the previous level
	logic [2:0] sda_sync;
	bus_event_t events_nxt;

	// ****************************************
	// Edge and condition decode
	// ****************************************
	always_comb
	begin
		events_nxt.scl_rise = scl_sync[1] & ~scl_sync[2];
		events_nxt.scl_fall = ~scl_sync[1] & scl_sync[2];
		// SDA falling with SCL high
		events_nxt.start    = scl_sync[1] & sda_sync[2] & ~sda_sync[1];
		// SDA rising with SCL high
		events_nxt.stop     = scl_sync[1] & ~sda_sync[2] & sda_sync[1];
		events_nxt.sda      = sda_sync[1];   // Aligned with the SCL strobes
	end

	// Pin to event is 3 cycles
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			scl_sync <= 3'b111;   // Idle bus is high
			sda_sync <= 3'b111;
			events   <= '{scl_rise: 1'b0, scl_fall: 1'b0, start: 1'b0, stop: 1'b0, sda: 1'b1};
		end
		else
		begin
			scl_sync <= {scl_sync[1:0], scl};
			sda_sync <= {sda_sync[1:0], sda_in};
			events   <= events_nxt;
		end
	end

endmodule

/* hw/i2c_byte_engine.sv */
// No clock stretching; SDA is only ever pulled low so the pad needs an open drain and a pull-up
module i2c_byte_engine
(
	input  logic                          SYSCLK,
	input  logic                          RESET_N,
	input  i2c_slave_pkg::bus_event_t     events,
	input  i2c_slave_pkg::engine_ctrl_t   ctrl,
	output i2c_slave_pkg::engine_status_t status,
	output logic                          sda_pull_low
);
	import i2c_slave_pkg::*;

	logic [3:0] bit_cnt;       // SCL rises in this byte and 9 is the ACK bit
	byte_t      rx_shift;      // MSB first
	byte_t      tx_shift;      // Bit 7 is on the bus
	logic       master_nack;
	logic       last_bit;
	logic       ack_bit;
	logic       shift_bit;

	assign last_bit  = (bit_cnt == 4'd8);
	assign ack_bit   = (bit_cnt == 4'd9);
	assign shift_bit = (bit_cnt != 4'd0) & (bit_cnt < 4'd8);   // Falls after bits 1 to 7

	// ****************************************
	// Bit counter
	// ****************************************
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
			bit_cnt <= 4'd0;
		else if (events.start | events.stop)
			bit_cnt <= 4'd0;                   // Resync on any bus condition
		else if (events.scl_rise)
			bit_cnt <= bit_cnt + 4'd1;
		else if (events.scl_fall & ack_bit)
			bit_cnt <= 4'd0;                   // ACK slot over
	end

	// ****************************************
	// Shift registers
	// ****************************************
	always_ff @(posedge SYSCLK)
	begin
		// Data bits are sampled while SCL is high
		if (events.scl_rise & (bit_cnt < 4'd8))
			rx_shift <= {rx_shift[BYTE_W-2:0], events.sda};

		if (events.scl_fall & ack_bit)
			tx_shift <= ctrl.tx_byte;          // Next byte to send
		else if (events.scl_fall & shift_bit & ctrl.tx_mode)
			tx_shift <= {tx_shift[BYTE_W-2:0], 1'b0};
	end

	// Master answer in the ACK slot of a sent byte
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
			master_nack <= 1'b0;
		else if (events.scl_rise & last_bit)
			master_nack <= events.sda;         // High means NACK
	end

	// ****************************************
	// SDA pull-down
	// ****************************************
	// Only changes after an SCL fall so SDA is stable while SCL is high
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
			sda_pull_low <= 1'b0;
		else if (events.start | events.stop)
			sda_pull_low <= 1'b0;
		else if (events.scl_fall)
		begin
			if (last_bit)
				sda_pull_low <= ctrl.ack_en;                       // Our ACK or release
			else if (ack_bit)
				sda_pull_low <= ctrl.tx_mode & ~ctrl.tx_byte[BYTE_W-1];   // First bit out
			else if (shift_bit & ctrl.tx_mode)
				sda_pull_low <= ~tx_shift[BYTE_W-2];               // Drive zeros only
		end
	end

	// Strobes follow the SCL fall event in the same cycle
	assign status.byte_done   = events.scl_fall & last_bit;
	assign status.ack_done    = events.scl_fall & ack_bit;
	assign status.master_nack = master_nack;
	assign status.rx          = rx_shift;

endmodule

/* hw/i2c_reg_slave.sv */
// 7-bit addressing only with no general call and no clock stretching; outputs are strobes
module i2c_reg_slave
#(
	parameter bit CHECKSUM_EN = 1'b1    // 0 drops the checksum byte
)
(
	input  logic                             SYSCLK,
	input  logic                             RESET_N,
	input  logic                             scl,
	input  logic                             sda_in,
	output logic                             sda_pull_low,   // Open-drain drive
	input  logic [i2c_slave_pkg::ADDR_W-1:0] slave_addr,
	input  i2c_slave_pkg::port_data_t        din,
	output i2c_slave_pkg::byte_t             dout,
	output logic                             rd_wr,
	output i2c_slave_pkg::port_onehot_t      port_cs,
	output i2c_slave_pkg::port_onehot_t      offset_sel
);
	import i2c_slave_pkg::*;

	bus_event_t     bus_events;
	engine_status_t eng_status;
	engine_ctrl_t   eng_ctrl;
	byte_t          loc;
	byte_t          read_byte;
	logic           port_strobe;

	// Pins to event strobes
	i2c_bus_sampler sampler_inst
	(
		.SYSCLK       (SYSCLK),
		.RESET_N      (RESET_N),
		.scl          (scl),
		.sda_in       (sda_in),
		.events       (bus_events)
	);

	// Bits to bytes
	i2c_byte_engine engine_inst
	(
		.SYSCLK       (SYSCLK),
		.RESET_N      (RESET_N),
		.events       (bus_events),
		.ctrl         (eng_ctrl),
		.status       (eng_status),
		.sda_pull_low (sda_pull_low)
	);

	i2c_transaction_ctrl #(.CHECKSUM_EN(CHECKSUM_EN)) ctrl_inst
	(
		.SYSCLK       (SYSCLK),
		.RESET_N      (RESET_N),
		.events       (bus_events),
		.status       (eng_status),
		.slave_addr   (slave_addr),
		.read_byte    (read_byte),
		.ctrl         (eng_ctrl),
		.loc          (loc),
		.port_strobe  (port_strobe),
		.dout         (dout),
		.rd_wr        (rd_wr)
	);

	reg_port_select select_inst
	(
		.SYSCLK       (SYSCLK),
		.RESET_N      (RESET_N),
		.loc          (loc),
		.port_strobe  (port_strobe),
		.din          (din),
		.port_cs      (port_cs),
		.offset_sel   (offset_sel),
		.read_byte    (read_byte)
	);

endmodule

/* hw/i2c_slave_pkg.sv */
// Shared types for the I2C port slave with 16 ports of 8 bits and a 4-bit port and offset field
package i2c_slave_pkg;

	// ****************************************
	// Widths
	// ****************************************
	localparam int BYTE_W    = 8;                  // One bus byte
	localparam int ADDR_W    = 7;                  // 7-bit slave address only
	localparam int NUM_PORTS = 16;                 // Ports behind the slave
	localparam int SEL_W     = $clog2(NUM_PORTS);  // Port or offset nibble

	typedef logic [BYTE_W-1:0]                  byte_t;
	typedef logic [NUM_PORTS-1:0]               port_onehot_t;
	typedef logic [NUM_PORTS-1:0][BYTE_W-1:0]   port_data_t;   // Port n input at [n]

	// One-hot transaction states
	typedef enum logic [6:0] {
		IDLE  = 7'b000_0001,   // Bus free or not addressed
		ADDR  = 7'b000_0010,   // Slave address and R/W bit
		LOC   = 7'b000_0100,   // Location byte
		DATA  = 7'b000_1000,   // Write data byte
		CHECK = 7'b001_0000,   // Checksum byte
		READ  = 7'b010_0000,   // Bytes sent to the master
		END   = 7'b100_0000    // Write done and further bytes get no ACK
	} i2c_state_e;

	// ****************************************
	// Block to block bundles
	// ****************************************
	typedef struct packed {
		logic scl_rise;   // Single-cycle strobes
		logic scl_fall;
		logic start;
		logic stop;
		logic sda;        // Synchronized SDA level
	} bus_event_t;

	// Same received byte read two ways
	typedef union packed {
		struct packed {
			logic [ADDR_W-1:0] addr;
			logic              rw;       // 1 for read
		} addr_rw;                       // In state ADDR
		struct packed {
			logic [SEL_W-1:0]  port;     // Upper nibble
			logic [SEL_W-1:0]  offset;   // Lower nibble
		} sel;                           // In state LOC
	} rx_byte_u;

	typedef struct packed {
		logic     byte_done;     // SCL fall ending bit 8
		logic     ack_done;      // SCL fall ending the ACK bit
		logic     master_nack;   // SDA level seen in the last ACK slot
		rx_byte_u rx;
	} engine_status_t;

	typedef struct packed {
		logic  ack_en;    // Pull SDA low in the coming ACK slot
		logic  tx_mode;   // Coming bytes go out to the master
		byte_t tx_byte;   // Loaded at the next ACK end
	} engine_ctrl_t;

endpackage

/* hw/i2c_transaction_ctrl.sv */
// Reads use the location of the last write; writes need data plus checksum zero when CHECKSUM_EN is 1
module i2c_transaction_ctrl
#(
	parameter bit CHECKSUM_EN = 1'b1
)
(
	input  logic                             SYSCLK,
	input  logic                             RESET_N,
	input  i2c_slave_pkg::bus_event_t        events,
	input  i2c_slave_pkg::engine_status_t    status,
	input  logic [i2c_slave_pkg::ADDR_W-1:0] slave_addr,
	input  i2c_slave_pkg::byte_t             read_byte,
	output i2c_slave_pkg::engine_ctrl_t      ctrl,
	output i2c_slave_pkg::byte_t             loc,
	output logic                             port_strobe,
	output i2c_slave_pkg::byte_t             dout,
	output logic                             rd_wr
);
	import i2c_slave_pkg::*;

	i2c_state_e state;
	i2c_state_e state_nxt;
	byte_t      rx_byte;       // Received byte as a plain vector
	byte_t      data_q;        // Data byte waiting for its checksum
	byte_t      chk_sum;
	byte_t      wr_byte;
	byte_t      tx_byte_q;
	logic       addr_match;
	logic       commit;
	logic       fetch;
	logic       fetch_q;       // read_byte is valid in this cycle
	logic       rd_ack_slot;   // Between a sent byte and its ACK end
	logic       rd_ack_rise;   // One cycle after the master ACK is sampled

	assign rx_byte    = status.rx;
	assign addr_match = (status.rx.addr_rw.addr == slave_addr);
	assign chk_sum    = data_q + rx_byte;
	assign wr_byte    = CHECKSUM_EN ? data_q : rx_byte;   // Without checksum the data byte commits

	// ****************************************
	// Port strobes
	// ****************************************
	assign commit = status.byte_done &
		(CHECKSUM_EN ? ((state == CHECK) & (chk_sum == 8'h00)) : (state == DATA));

	// First fetch on a read address match and then one per master ACK
	assign fetch = (status.byte_done & (state == ADDR) & addr_match & status.rx.addr_rw.rw) |
		(rd_ack_rise & (state == READ) & ~status.master_nack);

	assign port_strobe = commit | fetch;

	// Engine controls
	always_comb
	begin
		case (state)
			ADDR:             ctrl.ack_en = addr_match;   // Stay silent for other slaves
			LOC, DATA, CHECK: ctrl.ack_en = 1'b1;         // Bad checksum still gets its ACK
			default:          ctrl.ack_en = 1'b0;         // Master answers on reads
		endcase
		ctrl.tx_mode = (state == READ) & ~status.master_nack;   // NACK ends sending
		ctrl.tx_byte = tx_byte_q;
	end

	// ****************************************
	// State machine
	// ****************************************
	always_comb
	begin
		state_nxt = state;
		if (events.start)
			state_nxt = ADDR;      // START and repeated START
		else if (events.stop)
			state_nxt = IDLE;
		else
		begin
			case (state)
				ADDR:
					if (status.byte_done)
						state_nxt = !addr_match ? IDLE : (status.rx.addr_rw.rw ? READ : LOC);
				LOC:
					if (status.byte_done)
						state_nxt = DATA;
				DATA:
					if (status.byte_done)
						state_nxt = CHECKSUM_EN ? CHECK : END;
				CHECK:
					if (status.byte_done)
						state_nxt = END;
				READ:
					if (status.ack_done & status.master_nack)
						state_nxt = IDLE;
				IDLE, END:
					state_nxt = state;     // Wait for a bus condition
				default:
					state_nxt = IDLE;
			endcase
		end
	end

	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state       <= IDLE;
			loc         <= 8'h00;
			dout        <= 8'h00;
			rd_wr       <= 1'b0;
			rd_ack_slot <= 1'b0;
			rd_ack_rise <= 1'b0;
			fetch_q     <= 1'b0;
		end
		else
		begin
			state <= state_nxt;

			if (events.stop)
				rd_wr <= 1'b0;
			else if ((state == ADDR) & status.byte_done & addr_match)
				rd_wr <= status.rx.addr_rw.rw;

			if ((state == LOC) & status.byte_done)
				loc <= {status.rx.sel.port, status.rx.sel.offset};
			else if ((state == READ) & status.byte_done)
				loc <= loc + 8'd1;                 // Also after the NACKed byte

			if (commit)
				dout <= wr_byte;                   // Holds until the next commit

			if (events.start | events.stop | status.ack_done)
				rd_ack_slot <= 1'b0;
			else if ((state == READ) & status.byte_done)
				rd_ack_slot <= 1'b1;

			rd_ack_rise <= rd_ack_slot & events.scl_rise;
			fetch_q     <= fetch;
		end
	end

	// Payload
	always_ff @(posedge SYSCLK)
	begin
		if ((state == DATA) & status.byte_done)
			data_q <= rx_byte;
		if (fetch_q)
			tx_byte_q <= read_byte;    // Long before the ACK slot ends
	end

endmodule

/* hw/reg_port_select.sv */
// Port strobes are single cycle with no handshake so a port must take them when they occur
module reg_port_select
(
	input  logic                        SYSCLK,
	input  logic                        RESET_N,
	input  i2c_slave_pkg::byte_t        loc,
	input  logic                        port_strobe,
	input  i2c_slave_pkg::port_data_t   din,
	output i2c_slave_pkg::port_onehot_t port_cs,
	output i2c_slave_pkg::port_onehot_t offset_sel,
	output i2c_slave_pkg::byte_t        read_byte
);
	import i2c_slave_pkg::*;

	logic [SEL_W-1:0] port_idx;     // Upper nibble of loc
	logic [SEL_W-1:0] offset_idx;   // Lower nibble of loc
	port_onehot_t     port_dec;

	function automatic port_onehot_t onehot(input logic [SEL_W-1:0] idx);
		port_onehot_t mask;
		mask      = '0;
		mask[idx] = 1'b1;
		return mask;
	endfunction

	assign port_idx   = loc[BYTE_W-1 -: SEL_W];
	assign offset_idx = loc[SEL_W-1:0];
	assign port_dec   = onehot(port_idx);
	assign offset_sel = onehot(offset_idx);     // Level and follows loc

	// One pulse per commit or fetch
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
			port_cs <= '0;
		else
			port_cs <= port_strobe ? port_dec : '0;
	end

	// Captured with port_cs
	always_ff @(posedge SYSCLK)
	begin
		if (port_strobe)
			read_byte <= din[port_idx];
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the I2C slave testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_i2c_reg_slave -f sources.f

./obj_dir/Vtb_i2c_reg_slave > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Testbench failed" sim.log
then
	exit 1
fi
exit 0

/* sources.f */
+incdir+tb
hw/i2c_slave_pkg.sv
hw/i2c_bus_sampler.sv
hw/i2c_byte_engine.sv
hw/i2c_transaction_ctrl.sv
hw/reg_port_select.sv
hw/i2c_reg_slave.sv
tb/tb_i2c_reg_slave.sv

/* tb/i2c_master_bfm.svh */
// Master tasks for the testbench module; SCL phases last 10 SYSCLK cycles with no clock stretching
`ifndef I2C_MASTER_BFM_SVH
`define I2C_MASTER_BFM_SVH

localparam int QUARTER     = 5;    // SYSCLK cycles per quarter SCL period
localparam int SDA_TIMEOUT = 40;   // Cycles to wait for a released SDA

// Step to the next drive point just after a rising clock edge
task automatic bus_delay(input int cycles);
	repeat (cycles) @(posedge SYSCLK);
	#2;
endtask

// Wait for SDA to float high before a bus condition
task automatic wait_sda_free(input string where);
	int waited;
	waited = 0;
	do
	begin
		bus_delay(1);
		waited++;
	end
	while (sda_in !== 1'b1 && waited < SDA_TIMEOUT);
	if (sda_in !== 1'b1)
	begin
		$display("timeout: the slave still holds SDA low %s", where);
		errors++;
	end
endtask

// ****************************************
// Bus conditions
// ****************************************
task automatic send_start();
	if (scl_drv == 1'b0)
	begin
		bus_delay(QUARTER);          // Repeated START so SCL comes back up first
		sda_drv = 1'b1;
		bus_delay(QUARTER);
		scl_drv = 1'b1;
	end
	wait_sda_free("before START");
	bus_delay(2 * QUARTER);
	sda_drv = 1'b0;                  // SDA falls with SCL high
	bus_delay(2 * QUARTER);
	scl_drv = 1'b0;
endtask

task automatic send_stop();
	bus_delay(QUARTER);
	sda_drv = 1'b0;
	bus_delay(QUARTER);
	scl_drv = 1'b1;
	bus_delay(2 * QUARTER);
	sda_drv = 1'b1;                  // SDA rises with SCL high
	wait_sda_free("at STOP");
	bus_delay(2 * QUARTER);
endtask

// ****************************************
// Bits and bytes
// ****************************************
// Enters and leaves with SCL low
task automatic clock_bit(input logic drive, output logic seen);
	bus_delay(QUARTER);
	sda_drv = drive;                 // Middle of the low phase
	bus_delay(QUARTER);
	scl_drv = 1'b1;
	bus_delay(QUARTER);
	seen = sda_in;                   // Middle of the high phase
	bus_delay(QUARTER);
	scl_drv = 1'b0;
endtask

task automatic transmit_byte(input byte_t value, output logic acked);
	logic seen;
	int   i;
	for (i = BYTE_W - 1; i >= 0; i--)
		clock_bit(value[i], seen);   // MSB first
	clock_bit(1'b1, seen);           // Released for the slave ACK
	acked = ~seen;
endtask

task automatic receive_byte(input logic nack, output byte_t value);
	logic seen;
	int   i;
	for (i = BYTE_W - 1; i >= 0; i--)
	begin
		clock_bit(1'b1, seen);
		value[i] = seen;
	end
	clock_bit(nack, seen);           // High ends the read
endtask

`endif

/* tb/tb_i2c_reg_slave.sv */
// Runs one slave at address 7'h57 with the checksum on; needs an event-driven simulator with delays
module tb_i2c_reg_slave;
	import i2c_slave_pkg::*;

	typedef enum logic [1:0] {KIND_WRITE, KIND_READ} kind_e;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		byte_t             loc;      // Port nibble and offset nibble
		byte_t             data;
		byte_t             chk;
		kind_e             kind;
		logic              commit;   // Write expected to reach a port
	} test_t;

	localparam logic [ADDR_W-1:0] SLAVE_ADDR = 7'h57;
	localparam int NUM_TESTS     = 5;
	localparam int PULSE_TIMEOUT = 100;

	logic         SYSCLK;
	logic         RESET_N;
	logic         scl_drv;
	logic         sda_drv;
	logic         sda_in;
	logic         sda_pull_low;
	port_data_t   din;
	byte_t        dout;
	logic         rd_wr;
	port_onehot_t port_cs;
	port_onehot_t offset_sel;

	test_t        tests [NUM_TESTS];
	port_onehot_t cs_log [$];
	byte_t        dout_log [$];
	logic         pull_seen;   // Slave pulled SDA low in this test
	int           errors;
	int           passed;
	int           failed;

	assign sda_in = sda_drv & ~sda_pull_low;   // Wired-AND with the pull-up

	i2c_reg_slave #(.CHECKSUM_EN(1'b1)) i2c_reg_slave_inst
	(
		.SYSCLK       (SYSCLK),
		.RESET_N      (RESET_N),
		.scl          (scl_drv),
		.sda_in       (sda_in),
		.sda_pull_low (sda_pull_low),
		.slave_addr   (SLAVE_ADDR),
		.din          (din),
		.dout         (dout),
		.rd_wr        (rd_wr),
		.port_cs      (port_cs),
		.offset_sel   (offset_sel)
	);

	always #10 SYSCLK = ~SYSCLK;

	// Port strobe and SDA drive monitor sampled away from the rising edge
	always @(negedge SYSCLK)
	begin
		if (port_cs != '0)
		begin
			cs_log.push_back(port_cs);
			dout_log.push_back(dout);   // Valid in the pulse cycle
		end
		if (sda_pull_low === 1'b1)
			pull_seen = 1'b1;
	end

	`include "i2c_master_bfm.svh"

	task automatic report_mismatch(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		$display("error %s got %h expected %h", name, got, exp);
		errors++;
	endtask

	task automatic log_result(input string name, input int errors_before);
		if (errors == errors_before)
		begin
			passed++;
			$display("%s: ok", name);
		end
		else
		begin
			failed++;
			$display("%s: %0d errors", name, errors - errors_before);
		end
	endtask

	// ****************************************
	// Tests
	// ****************************************
	task automatic check_idle();
		int errors_before;
		int cycles;
		errors_before = errors;
		if (port_cs !== '0) report_mismatch("port_cs", port_cs, 16'h0);
		if (rd_wr !== 1'b0) report_mismatch("rd_wr", 16'(rd_wr), 16'h0);
		if (dout !== 8'h00) report_mismatch("dout", 16'(dout), 16'h0);
		for (cycles = 0; cycles < 20; cycles++)
		begin
			bus_delay(1);
			if (sda_pull_low !== 1'b0) report_mismatch("sda_pull_low", 16'(sda_pull_low), 16'h0);
		end
		log_result("test reset and idle bus", errors_before);
	endtask

	task automatic run_test(input int idx);
		test_t        t;
		logic         acked;
		logic         ack_exp;
		byte_t        rd_val;
		logic [3:0]   off_idx;
		port_onehot_t cs_exp;
		port_onehot_t off_exp;
		int           pulses;
		int           waited;
		int           errors_before;
		int           k;
		t             = tests[idx];
		errors_before = errors;
		ack_exp       = (t.addr == SLAVE_ADDR);   // Other addresses get no ACK at all
		cs_exp        = '0;
		cs_exp[t.loc[7:4]] = 1'b1;
		// Location steps once per byte read and once more for the NACKed one
		off_idx       = (t.kind == KIND_READ) ? t.loc[3:0] + 4'd2 : t.loc[3:0];
		off_exp       = '0;
		off_exp[off_idx] = 1'b1;
		pulses        = (t.kind == KIND_READ) ? 2 : (t.commit ? 1 : 0);
		cs_log.delete();
		dout_log.delete();
		pull_seen     = 1'b0;

		send_start();
		transmit_byte({t.addr, 1'b0}, acked);
		if (acked !== ack_exp) report_mismatch("address ack", 16'(acked), 16'(ack_exp));
		transmit_byte(t.loc, acked);
		if (acked !== ack_exp) report_mismatch("location ack", 16'(acked), 16'(ack_exp));
		if (t.kind == KIND_WRITE)
		begin
			transmit_byte(t.data, acked);
			if (acked !== ack_exp) report_mismatch("data ack", 16'(acked), 16'(ack_exp));
			transmit_byte(t.chk, acked);
			if (acked !== ack_exp) report_mismatch("checksum ack", 16'(acked), 16'(ack_exp));
		end
		else
		begin
			send_start();                // Repeated START into the read
			transmit_byte({t.addr, 1'b1}, acked);
			if (acked !== ack_exp) report_mismatch("read address ack", 16'(acked), 16'(ack_exp));
			for (k = 0; k < 2; k++)
			begin
				receive_byte(k == 1, rd_val);   // Second byte gets the NACK
				if (rd_val !== din[t.loc[7:4]])
					report_mismatch("read byte", 16'(rd_val), 16'(din[t.loc[7:4]]));
			end
			if (rd_wr !== 1'b1) report_mismatch("rd_wr", 16'(rd_wr), 16'h1);
		end
		send_stop();

		// An unaddressed slave never touches SDA
		if (!ack_exp && pull_seen !== 1'b0)
			report_mismatch("sda_pull_low", 16'(pull_seen), 16'h0);

		waited = 0;
		while (cs_log.size() < pulses && waited < PULSE_TIMEOUT)
		begin
			bus_delay(1);
			waited++;
		end
		if (cs_log.size() < pulses)
		begin
			$display("timeout: only %0d of %0d port_cs pulses came", cs_log.size(), pulses);
			errors++;
		end
		else if (cs_log.size() > pulses)
			report_mismatch("port_cs pulse count", 16'(cs_log.size()), 16'(pulses));

		for (k = 0; k < cs_log.size(); k++)
			if (cs_log[k] !== cs_exp) report_mismatch("port_cs", cs_log[k], cs_exp);
		if (pulses > 0 && offset_sel !== off_exp)
			report_mismatch("offset_sel", offset_sel, off_exp);
		if (t.kind == KIND_WRITE && t.commit && dout_log.size() > 0)
		begin
			if (dout_log[0] !== t.data) report_mismatch("dout", 16'(dout_log[0]), 16'(t.data));
			if (dout !== t.data) report_mismatch("dout held", 16'(dout), 16'(t.data));
		end
		log_result($sformatf("test %0d %s loc %h", idx,
			(t.kind == KIND_READ) ? "read" : "write", t.loc), errors_before);
	endtask

	// ****************************************
	// Main sequence
	// ****************************************
	initial
	begin
		int i;
		errors    = 0;
		passed    = 0;
		failed    = 0;
		pull_seen = 1'b0;
		SYSCLK    = 1'b0;
		RESET_N   = 1'b0;
		scl_drv   = 1'b1;   // Idle bus
		sda_drv   = 1'b1;
		void'($urandom(32'hf6644438));
		for (i = 0; i < NUM_PORTS; i++)
			din[i] = 8'($urandom());

		tests[0] = '{SLAVE_ADDR, 8'h3a, 8'h5c, 8'ha4, KIND_WRITE, 1'b1};   // Sum is zero
		tests[1] = '{SLAVE_ADDR, 8'h71, 8'h20, 8'h11, KIND_WRITE, 1'b0};   // Sum 31
		tests[2] = '{7'h22, 8'h45, 8'h10, 8'hf0, KIND_WRITE, 1'b0};        // Other slave
		tests[3] = '{SLAVE_ADDR, 8'hc6, 8'h00, 8'h00, KIND_READ, 1'b1};
		tests[4] = '{SLAVE_ADDR, 8'hf0, 8'h01, 8'hff, KIND_WRITE, 1'b1};   // Top port

		repeat (4) @(posedge SYSCLK);
		#2;
		RESET_N = 1'b1;

		check_idle();
		for (i = 0; i < NUM_TESTS; i++)
			run_test(i);

		$display("tests %0d passed %0d failed %0d errors %0d", passed + failed, passed, failed,
			errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
